// File: source/bus_pkg.sv
package bus_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int ADDR_W   = 16;
    localparam int DATA_W   = 8;
    localparam int REGION_W = 4;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [REGION_W-1:0] region_t;

    // Single-cycle request from the master
    typedef struct packed {
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } bus_req_t;

    // Response, one cycle after the strobe
    typedef struct packed {
        logic  ack;
        logic  err;
        data_t dat;
    } bus_rsp_t;

    // ------------------------------
    // Address map, 4k per region
    // ------------------------------
    localparam region_t MEM_REGION = region_t'(0);
    localparam region_t PIC_REGION = region_t'(4);

    // Top address bits select the region
    function automatic region_t region_of(addr_t adr);
        return adr[ADDR_W-1 -: REGION_W];
    endfunction

endpackage

// File: source/irq_pkg.sv
package irq_pkg;

    // One bit per interrupt source
    localparam int IRQ_W = 8;

    typedef logic [IRQ_W-1:0] irq_vec_t;

    // ------------------------------
    // Controller register map
    // ------------------------------

    // Registers are picked by the low address nibble
    localparam int PIC_OFS_W = 4;

    typedef logic [PIC_OFS_W-1:0] pic_ofs_t;

    // Enable mask, written as a whole
    localparam pic_ofs_t PIC_ENABLE_OFS = pic_ofs_t'(0);

    // Pending bits, write 1 to clear
    localparam pic_ofs_t PIC_PENDING_OFS = pic_ofs_t'(1);

endpackage

// File: source/data_memory.sv
module data_memory
    import bus_pkg::*;
#(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic     wb_clk_i,
    input  logic     rst_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    localparam int DEPTH = 2 ** DMEM_ADDR_W;

    data_t                  mem_q [DEPTH];
    logic [DMEM_ADDR_W-1:0] mem_idx;
    data_t                  rd_dat_q;
    logic                   ack_q;

    // Low address bits only, so the region aliases modulo the depth
    assign mem_idx = req_i.adr[DMEM_ADDR_W-1:0];

    // ------------------------------
    // Storage and read port
    // ------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (req_i.stb) begin
            if (req_i.we) begin
                mem_q[mem_idx] <= req_i.dat;
                // writes answer with zero data
                rd_dat_q <= '0;
            end else begin
                rd_dat_q <= mem_q[mem_idx];
            end
        end
    end

    // One acknowledge per strobe, next cycle
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.stb;
        end
    end

    always_comb begin
        rsp_o.ack = ack_q;
        rsp_o.err = 1'b0;
        rsp_o.dat = rd_dat_q;
    end

endmodule

// File: source/interrupt_controller.sv
module interrupt_controller
    import bus_pkg::*;
    import irq_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,
    input  irq_vec_t irq_i,
    output logic     int_o
);

    pic_ofs_t reg_ofs;
    logic     wr_stb;
    irq_vec_t enable_q;
    irq_vec_t enable_d;
    irq_vec_t pending_q;
    irq_vec_t pending_d;
    irq_vec_t clr_mask;
    logic     int_q;
    logic     ack_q;
    data_t    rd_dat_q;

    assign reg_ofs = req_i.adr[PIC_OFS_W-1:0];
    assign wr_stb  = req_i.stb & req_i.we;

    // ------------------------------
    // Next register values
    // ------------------------------
    always_comb begin
        enable_d = enable_q;
        clr_mask = '0;
        if (wr_stb && reg_ofs == PIC_ENABLE_OFS) begin
            enable_d = irq_vec_t'(req_i.dat);
        end
        if (wr_stb && reg_ofs == PIC_PENDING_OFS) begin
            clr_mask = irq_vec_t'(req_i.dat);
        end
        // Set after clear, so a live source keeps its bit
        pending_d = (pending_q & ~clr_mask) | irq_i;
    end

    // Control state
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            enable_q  <= '0;
            pending_q <= '0;
            int_q     <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            enable_q  <= enable_d;
            pending_q <= pending_d;
            // Taken from the new values, so int_o moves with pending
            int_q     <= |(pending_d & enable_d);
            ack_q     <= req_i.stb;
        end
    end

    // ------------------------------
    // Read data
    // ------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (req_i.stb) begin
            if (req_i.we) begin
                rd_dat_q <= '0;
            end else begin
                case (reg_ofs)
                    PIC_ENABLE_OFS:  rd_dat_q <= data_t'(enable_q);
                    PIC_PENDING_OFS: rd_dat_q <= data_t'(pending_q);
                    default:         rd_dat_q <= '0;
                endcase
            end
        end
    end

    always_comb begin
        rsp_o.ack = ack_q;
        rsp_o.err = 1'b0;
        rsp_o.dat = rd_dat_q;
    end

    assign int_o = int_q;

endmodule

// File: source/bus_fabric.sv
module bus_fabric
    import bus_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_i,

    // Master side
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,

    // Slave side
    output bus_req_t mem_req_o,
    output bus_req_t pic_req_o,
    input  bus_rsp_t mem_rsp_i,
    input  bus_rsp_t pic_rsp_i
);

    region_t region;
    logic    mem_sel;
    logic    pic_sel;
    logic    unmapped;
    logic    err_q;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign region   = region_of(req_i.adr);
    assign mem_sel  = (region == MEM_REGION);
    assign pic_sel  = (region == PIC_REGION);
    assign unmapped = ~mem_sel & ~pic_sel;

    // Both slaves see we, adr and dat
    // only the selected one sees the strobe
    always_comb begin
        mem_req_o     = req_i;
        pic_req_o     = req_i;
        mem_req_o.stb = req_i.stb & mem_sel;
        pic_req_o.stb = req_i.stb & pic_sel;
    end

    // Error answer for requests outside the map
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i.stb & unmapped;
        end
    end

    // ------------------------------
    // Response merge
    // ------------------------------

    // Each request hit exactly one target a cycle ago, so at most one
    // of the three strobes is high here
    always_comb begin
        rsp_o.ack = mem_rsp_i.ack | pic_rsp_i.ack;
        rsp_o.err = err_q;
        if (mem_rsp_i.ack) begin
            rsp_o.dat = mem_rsp_i.dat;
        end else if (pic_rsp_i.ack) begin
            rsp_o.dat = pic_rsp_i.dat;
        end else begin
            // Idle and error cycles carry no data
            rsp_o.dat = '0;
        end
    end

endmodule

// File: source/data_bus_system.sv
module data_bus_system
    import bus_pkg::*;
    import irq_pkg::*;
#(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic     wb_clk_i,
    input  logic     rst_i,

    // Data bus master port
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,

    // Peripheral interrupt lines
    input  irq_vec_t irq_i,
    output logic     int_o
);

    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    bus_req_t pic_req;
    bus_rsp_t pic_rsp;

    // ------------------------------
    // Decoder and response merge
    // ------------------------------
    bus_fabric u_bus_fabric (
        .wb_clk_i  ( wb_clk_i ),
        .rst_i     ( rst_i    ),
        .req_i     ( req_i    ),
        .rsp_o     ( rsp_o    ),
        .mem_req_o ( mem_req  ),
        .pic_req_o ( pic_req  ),
        .mem_rsp_i ( mem_rsp  ),
        .pic_rsp_i ( pic_rsp  )
    );

    // ------------------------------
    // Data memory, region 0
    // ------------------------------
    data_memory #(
        .DMEM_ADDR_W ( DMEM_ADDR_W )
    ) u_dmem (
        .wb_clk_i ( wb_clk_i ),
        .rst_i    ( rst_i    ),
        .req_i    ( mem_req  ),
        .rsp_o    ( mem_rsp  )
    );

    // ------------------------------
    // Interrupt controller, region 4
    // ------------------------------
    interrupt_controller u_pic (
        .wb_clk_i ( wb_clk_i ),
        .rst_i    ( rst_i    ),
        .req_i    ( pic_req  ),
        .rsp_o    ( pic_rsp  ),
        .irq_i    ( irq_i    ),
        .int_o    ( int_o    )
    );

endmodule

// File: tb/data_bus_system_tb.sv
module data_bus_system_tb
    import bus_pkg::*;
    import irq_pkg::*;
();

    localparam int    MEM_DEPTH       = 256;
    localparam int    REGION_SIZE     = 4096;
    localparam int    N_WORDS         = 8;
    localparam int    TIMEOUT         = 20;
    localparam addr_t PIC_ENABLE_ADR  = 16'h4000;
    localparam addr_t PIC_PENDING_ADR = 16'h4001;
    localparam addr_t UNMAPPED_ADR    = 16'h8000;

    logic     wb_clk_i;
    logic     rst_i;
    bus_req_t req_i;
    bus_rsp_t rsp_o;
    irq_vec_t irq_i;
    logic     int_o;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    data_t       mem_model [MEM_DEPTH];
    addr_t       test_adr  [N_WORDS];

    data_bus_system data_bus_system_i (
        .wb_clk_i ( wb_clk_i ),
        .rst_i    ( rst_i    ),
        .req_i    ( req_i    ),
        .rsp_o    ( rsp_o    ),
        .irq_i    ( irq_i    ),
        .int_o    ( int_o    )
    );

    always #2 wb_clk_i = ~wb_clk_i;

    // ------------------------------
    // Test data
    // ------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Memory aliases modulo its depth
    function automatic int model_idx(input addr_t addr);
        return int'(addr) % MEM_DEPTH;
    endfunction

    // ------------------------------
    // Checks and bus access
    // ------------------------------
    task automatic check_byte(input data_t got, input data_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Cycles are counted from the edge that drops the strobe
    task automatic wait_rsp(output bus_rsp_t rsp, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        rsp    = '0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge wb_clk_i);
            cycles++;
            if (rsp_o.ack || rsp_o.err) begin
                seen = 1'b1;
                rsp  = rsp_o;
            end
        end
        if (!seen) begin
            errors++;
            $display("Timeout: no ack or err within %0d cycles of a request", TIMEOUT);
        end else begin
            checks++;
            assert (cycles == 1) else begin
                errors++;
                $display("FAILED at %0t: response came %0d cycles late", $time, cycles);
            end
        end
    endtask

    task automatic bus_access(input logic is_write, input addr_t addr, input data_t wdat,
                              output bus_rsp_t rsp);
        int cycles;
        @(posedge wb_clk_i);
        req_i <= '{stb: 1'b1, we: is_write, adr: addr, dat: wdat};
        @(posedge wb_clk_i);
        req_i.stb <= 1'b0;
        wait_rsp(rsp, cycles);
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdat);
        bus_rsp_t rsp;
        bus_access(1'b1, addr, wdat, rsp);
        check_bit(rsp.ack, 1'b1, "write ack");
        check_bit(rsp.err, 1'b0, "write err");
        check_byte(rsp.dat, 8'h00, "write response data");
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdat);
        bus_rsp_t rsp;
        bus_access(1'b0, addr, 8'h00, rsp);
        check_bit(rsp.ack, 1'b1, "read ack");
        check_bit(rsp.err, 1'b0, "read err");
        rdat = rsp.dat;
    endtask

    task automatic pulse_irq(input irq_vec_t bits);
        @(posedge wb_clk_i);
        irq_i <= bits;
        @(posedge wb_clk_i);
        irq_i <= '0;
    endtask

    task automatic wait_int(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge wb_clk_i);
            cycles++;
        end while (int_o !== level && cycles < TIMEOUT);
        if (int_o !== level) begin
            errors++;
            $display("Timeout: int_o did not reach %b within %0d cycles", level, TIMEOUT);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_state();
        data_t rd;
        @(negedge wb_clk_i);
        check_bit(int_o, 1'b0, "int_o after reset");
        repeat (4) begin
            @(negedge wb_clk_i);
            check_bit(rsp_o.ack | rsp_o.err, 1'b0, "idle response strobe");
        end
        bus_read(PIC_ENABLE_ADR, rd);
        check_byte(rd, 8'h00, "ENABLE after reset");
        bus_read(PIC_PENDING_ADR, rd);
        check_byte(rd, 8'h00, "PENDING after reset");
    endtask

    task automatic test_memory_rw();
        data_t wdat;
        data_t rd;
        addr_t alias_adr;
        for (int i = 0; i < N_WORDS; i++) begin
            test_adr[i] = addr_t'(lfsr_bits(12));
            wdat        = data_t'(lfsr_bits(8));
            bus_write(test_adr[i], wdat);
            mem_model[model_idx(test_adr[i])] = wdat;
        end
        for (int i = 0; i < N_WORDS; i++) begin
            bus_read(test_adr[i], rd);
            check_byte(rd, mem_model[model_idx(test_adr[i])], "memory read back");
            // One depth higher, wrapped inside the 4k region
            alias_adr = addr_t'((int'(test_adr[i]) + MEM_DEPTH) % REGION_SIZE);
            bus_read(alias_adr, rd);
            check_byte(rd, mem_model[model_idx(test_adr[i])], "aliased memory read");
        end
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i <= N_WORDS; i++) begin
            @(posedge wb_clk_i);
            if (i < N_WORDS) begin
                req_i <= '{stb: 1'b1, we: 1'b0, adr: test_adr[N_WORDS-1-i], dat: 8'h00};
            end else begin
                req_i.stb <= 1'b0;
            end
            // Answer to the previous strobe
            if (i > 0) begin
                @(negedge wb_clk_i);
                check_bit(rsp_o.ack, 1'b1, "back-to-back ack");
                check_bit(rsp_o.err, 1'b0, "back-to-back err");
                check_byte(rsp_o.dat, mem_model[model_idx(test_adr[N_WORDS-i])],
                           "back-to-back read data");
            end
        end
        @(negedge wb_clk_i);
        check_bit(rsp_o.ack, 1'b0, "ack after the last read");
    endtask

    task automatic test_unmapped();
        bus_rsp_t rsp;
        data_t    wdat;
        data_t    rd;
        wdat = data_t'(lfsr_bits(8));
        bus_write(16'h0000, wdat);
        mem_model[0] = wdat;
        // Same low bits as location 0
        bus_access(1'b1, UNMAPPED_ADR, ~wdat, rsp);
        check_bit(rsp.err, 1'b1, "unmapped write err");
        check_bit(rsp.ack, 1'b0, "unmapped write ack");
        check_byte(rsp.dat, 8'h00, "unmapped write data");
        bus_access(1'b0, UNMAPPED_ADR, 8'h00, rsp);
        check_bit(rsp.err, 1'b1, "unmapped read err");
        check_bit(rsp.ack, 1'b0, "unmapped read ack");
        check_byte(rsp.dat, 8'h00, "unmapped read data");
        bus_read(16'h0000, rd);
        check_byte(rd, mem_model[0], "memory after unmapped write");
        for (int i = 0; i < N_WORDS; i++) begin
            bus_read(test_adr[i], rd);
            check_byte(rd, mem_model[model_idx(test_adr[i])], "memory after unmapped access");
        end
    endtask

    task automatic test_interrupts();
        data_t rd;
        int    cycles;
        bus_write(PIC_ENABLE_ADR, 8'h05);
        bus_read(PIC_ENABLE_ADR, rd);
        check_byte(rd, 8'h05, "ENABLE mask");

        // Source 1 is masked
        pulse_irq(8'h02);
        repeat (3) begin
            @(negedge wb_clk_i);
            check_bit(int_o, 1'b0, "int_o for a masked source");
        end
        bus_read(PIC_PENDING_ADR, rd);
        check_byte(rd, 8'h02, "PENDING after masked source");

        // Source 2 is enabled
        pulse_irq(8'h04);
        wait_int(1'b1, cycles);
        checks++;
        assert (cycles == 1) else begin
            errors++;
            $display("FAILED at %0t: int_o rose %0d cycles after irq", $time, cycles);
        end
        bus_read(PIC_PENDING_ADR, rd);
        check_byte(rd, 8'h06, "PENDING after enabled source");

        bus_write(PIC_PENDING_ADR, 8'h04);
        check_bit(int_o, 1'b0, "int_o after clear");
        bus_read(PIC_PENDING_ADR, rd);
        check_byte(rd, 8'h02, "PENDING after clear");

        // Live source wins over the clear
        @(posedge wb_clk_i);
        irq_i <= 8'h04;
        wait_int(1'b1, cycles);
        bus_write(PIC_PENDING_ADR, 8'h04);
        check_bit(int_o, 1'b1, "int_o held by a live source");
        bus_read(PIC_PENDING_ADR, rd);
        check_byte(rd, 8'h06, "PENDING after clear with live source");

        @(posedge wb_clk_i);
        irq_i <= '0;
        bus_write(PIC_PENDING_ADR, 8'h06);
        check_bit(int_o, 1'b0, "int_o after final clear");
        bus_read(PIC_PENDING_ADR, rd);
        check_byte(rd, 8'h00, "PENDING after final clear");
    endtask

    task automatic finish_run();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hd5ea;
        wb_clk_i   = 1'b0;
        rst_i      = 1'b1;
        req_i      = '0;
        irq_i      = '0;
        repeat (2) @(posedge wb_clk_i);
        rst_i <= 1'b0;
        test_reset_state();
        test_memory_rw();
        test_back_to_back();
        test_unmapped();
        test_interrupts();
        finish_run();
    end

endmodule

// File: data_bus_system.f
source/bus_pkg.sv
source/irq_pkg.sv
source/data_memory.sv
source/interrupt_controller.sv
source/bus_fabric.sv
source/data_bus_system.sv
tb/data_bus_system_tb.sv

// File: Bender.yml
package:
  name: data_bus_system

sources:
  - source/bus_pkg.sv
  - source/irq_pkg.sv
  - source/data_memory.sv
  - source/interrupt_controller.sv
  - source/bus_fabric.sv
  - source/data_bus_system.sv
  - target: test
    files:
      - tb/data_bus_system_tb.sv
